// File: design/prbs_pkg.sv
// PRBS7 only (x^7 + x^6 + 1), 64-bit words, non-inverted pattern, 32-bit wrapping counters
`default_nettype none

package prbs_pkg;

    localparam int WORD_WIDTH = 64;
    localparam int PRBS_ORDER = 7;

    typedef logic [WORD_WIDTH-1:0] prbs_word_t;
    typedef logic [PRBS_ORDER-1:0] prbs_state_t;
    typedef logic [6:0]            bit_count_t;   // 0 to 64 differing bits
    typedef logic [31:0]           err_count_t;

    // Generator state after reset
    localparam prbs_state_t PRBS_SEED = '1;

    // Lock hysteresis in words
    localparam int LOCK_GOOD_WORDS = 4;
    localparam int LOSS_BAD_WORDS  = 4;

    typedef enum logic {
        HUNT,
        LOCKED
    } chk_state_t;

endpackage

`default_nettype wire

// File: design/prbs_7_64b.sv
// Pure combinational 64-step PRBS7 advance; only prbs_q[6:0] is read, prbs_d[6:0] is the next state
`default_nettype none
`timescale 1ns/100ps

module prbs_7_64b
    import prbs_pkg::*;
(
    input  prbs_word_t prbs_q,
    output prbs_word_t prbs_d
);

    prbs_state_t lfsr;    // Running state while unrolling
    logic        fb;

    // Unrolls to the fixed xor network, oldest bit lands in prbs_d[63]
    always_comb begin
        lfsr   = prbs_q[PRBS_ORDER-1:0];
        fb     = 1'b0;
        prbs_d = '0;
        for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
            fb        = lfsr[6] ^ lfsr[5];   // x^7 + x^6 + 1
            prbs_d[i] = fb;
            lfsr      = {lfsr[PRBS_ORDER-2:0], fb};
        end
    end

endmodule

`default_nettype wire

// File: design/prbs_gen.sv
// One word per tx_enable cycle, 1-cycle latency; injection flips bit 0 of the output word only
`default_nettype none
`timescale 1ns/100ps

module prbs_gen
    import prbs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_enable,
    input  logic       inject_error,
    output prbs_word_t tx_data,
    output logic       tx_valid
);

    prbs_state_t state;
    prbs_word_t  next_word;

    prbs_7_64b i_prbs_7_64b (
        .prbs_q ({{(WORD_WIDTH - PRBS_ORDER){1'b0}}, state}),
        .prbs_d (next_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= PRBS_SEED;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= tx_enable;
            if (tx_enable) begin
                state <= next_word[PRBS_ORDER-1:0];   // Clean word, never the injected one
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_enable) begin
            tx_data <= next_word ^ prbs_word_t'(inject_error);
        end
    end

endmodule

`default_nettype wire

// File: design/prbs_check.sv
// First word after reset only seeds the reference; an error in bits 6:0 also hits the next word
`default_nettype none
`timescale 1ns/100ps

module prbs_check
    import prbs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  prbs_word_t rx_data,
    input  logic       rx_valid,
    output bit_count_t bit_errors,
    output logic       err_valid,
    output logic       locked
);

    prbs_state_t ref_state;    // Low bits of last received word
    logic        ref_valid;
    prbs_word_t  predicted;
    prbs_word_t  diff;
    bit_count_t  diff_count;
    logic        word_err;
    logic        compare;
    chk_state_t  chk_state;
    logic [2:0]  good_run;
    logic [2:0]  bad_run;

    prbs_7_64b i_prbs_7_64b (
        .prbs_q ({{(WORD_WIDTH - PRBS_ORDER){1'b0}}, ref_state}),
        .prbs_d (predicted)
    );

    assign diff       = rx_data ^ predicted;
    assign diff_count = bit_count_t'($countones(diff));
    assign word_err   = |diff;
    assign compare    = rx_valid && ref_valid;
    assign locked     = (chk_state == LOCKED);

    always_ff @(posedge clk) begin
        if (reset) begin
            ref_valid <= 1'b0;
            err_valid <= 1'b0;
            chk_state <= HUNT;
            good_run  <= '0;
            bad_run   <= '0;
        end else begin
            err_valid <= compare && word_err && (chk_state == LOCKED);
            if (rx_valid) begin
                ref_valid <= 1'b1;
            end
            if (compare) begin
                if (word_err) begin
                    good_run <= '0;
                    if (chk_state == LOCKED) begin
                        if (bad_run == 3'(LOSS_BAD_WORDS - 1)) begin
                            chk_state <= HUNT;   // Lost sync
                            bad_run   <= '0;
                        end else begin
                            bad_run <= bad_run + 3'd1;
                        end
                    end
                end else begin
                    bad_run <= '0;
                    if (chk_state == HUNT) begin
                        if (good_run == 3'(LOCK_GOOD_WORDS - 1)) begin
                            chk_state <= LOCKED;
                            good_run  <= '0;
                        end else begin
                            good_run <= good_run + 3'd1;
                        end
                    end
                end
            end
        end
    end

    // Reference follows the word as received, errors included
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            ref_state <= rx_data[PRBS_ORDER-1:0];
        end
        if (compare) begin
            bit_errors <= diff_count;
        end
    end

endmodule

`default_nettype wire

// File: design/prbs_err_count.sv
// Both counters wrap at 2^32; clear_counts wins over a same-cycle update
`default_nettype none
`timescale 1ns/100ps

module prbs_err_count
    import prbs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  bit_count_t bit_errors,
    input  logic       err_valid,
    input  logic       clear_counts,
    output err_count_t error_count,
    output err_count_t error_word_count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            error_count      <= '0;
            error_word_count <= '0;
        end else if (clear_counts) begin
            error_count      <= '0;
            error_word_count <= '0;
        end else if (err_valid) begin
            error_count      <= error_count + err_count_t'(bit_errors);
            error_word_count <= error_word_count + err_count_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/prbs_top.sv
// Loopback from tx_data to rx_data is closed outside; no back-pressure on either side
`default_nettype none
`timescale 1ns/100ps

module prbs_top
    import prbs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_enable,
    input  logic       inject_error,
    output prbs_word_t tx_data,
    output logic       tx_valid,
    input  prbs_word_t rx_data,
    input  logic       rx_valid,
    input  logic       clear_counts,
    output logic       locked,
    output err_count_t error_count,
    output err_count_t error_word_count
);

    bit_count_t bit_errors;
    logic       err_valid;

    prbs_gen i_prbs_gen (
        .clk          (clk),
        .reset        (reset),
        .tx_enable    (tx_enable),
        .inject_error (inject_error),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid)
    );

    prbs_check i_prbs_check (
        .clk        (clk),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .bit_errors (bit_errors),
        .err_valid  (err_valid),
        .locked     (locked)
    );

    prbs_err_count i_prbs_err_count (
        .clk              (clk),
        .reset            (reset),
        .bit_errors       (bit_errors),
        .err_valid        (err_valid),
        .clear_counts     (clear_counts),
        .error_count      (error_count),
        .error_word_count (error_word_count)
    );

endmodule

`default_nettype wire

// File: sim/tb_prbs_top.sv
// Loopback closed here; serial PRBS7 model checked every cycle, first error stops the run
`default_nettype none
`timescale 1ns/100ps

module tb_prbs_top
    import prbs_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       tx_enable;
    logic       inject_error;
    prbs_word_t tx_data;
    logic       tx_valid;
    prbs_word_t rx_data;
    logic       rx_valid;
    logic       clear_counts;
    logic       locked;
    err_count_t error_count;
    err_count_t error_word_count;

    logic        loopback;      // Receive side connected to transmit side
    int unsigned seed_val;
    int          fail_count;
    err_count_t  words_before;
    int          wait_cycles;

    // Model of the transmitter
    prbs_state_t m_gen_state;
    logic        m_tx_valid;
    prbs_word_t  m_tx_data;
    // Model of the checker and counters
    prbs_state_t m_ref_state;
    logic        m_ref_valid;
    logic        m_locked;
    int          m_good;
    int          m_bad;
    bit_count_t  m_bit_errors;
    logic        m_err_valid;
    err_count_t  m_err_count;
    err_count_t  m_word_count;

    prbs_top i_prbs_top (
        .clk              (clk),
        .reset            (reset),
        .tx_enable        (tx_enable),
        .inject_error     (inject_error),
        .tx_data          (tx_data),
        .tx_valid         (tx_valid),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .clear_counts     (clear_counts),
        .locked           (locked),
        .error_count      (error_count),
        .error_word_count (error_word_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Serial LFSR, one bit per step, oldest bit into bit 63
    function automatic prbs_word_t lfsr_word(input prbs_state_t start);
        prbs_state_t s;
        logic        b;
        prbs_word_t  w;
        s = start;
        w = '0;
        for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
            b    = s[6] ^ s[5];
            w[i] = b;
            s    = {s[5:0], b};
        end
        return w;
    endfunction

    function automatic int count_set_bits(input prbs_word_t w);
        int n;
        n = 0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            if (w[i]) n++;
        end
        return n;
    endfunction

    // One to eight bits set, never zero
    function automatic prbs_word_t random_mask();
        prbs_word_t  m;
        int          nbits;
        logic [5:0]  idx;
        m     = '0;
        nbits = 1 + int'($urandom % 8);
        for (int i = 0; i < nbits; i++) begin
            idx    = 6'($urandom % 64);
            m[idx] = 1'b1;
        end
        return m;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            fail_count++;
            $display("MISMATCH at %0t ns: %s, got %0h expected %0h",
                     $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic compare_outputs();
        check(64'(tx_valid), 64'(m_tx_valid), "tx_valid");
        if (m_tx_valid) begin
            check(tx_data, m_tx_data, "tx_data");
        end
        check(64'(locked), 64'(m_locked), "locked");
        check(64'(error_count), 64'(m_err_count), "error_count");
        check(64'(error_word_count), 64'(m_word_count), "error_word_count");
    endtask

    // Checks and drives at the falling edge, then advances the model over the rising edge
    task automatic run_cycle(input int tx_pct, input int inject_pct, input int corrupt_pct,
                             input logic clear);
        prbs_word_t mask;
        prbs_word_t word;
        prbs_word_t pred;
        int         diff_bits;
        logic       n_tx_en;
        logic       n_inject;
        @(negedge clk);
        compare_outputs();
        mask = '0;
        if (tx_valid && int'($urandom % 100) < corrupt_pct) mask = random_mask();
        n_tx_en  = int'($urandom % 100) < tx_pct;
        n_inject = n_tx_en && (int'($urandom % 100) < inject_pct);

        reset        = 1'b0;
        tx_enable    = n_tx_en;
        inject_error = n_inject;
        rx_valid     = loopback && tx_valid;
        rx_data      = tx_data ^ mask;
        clear_counts = clear;

        if (clear) begin
            m_err_count  = '0;
            m_word_count = '0;
        end else if (m_err_valid) begin
            m_err_count  = m_err_count + err_count_t'(m_bit_errors);
            m_word_count = m_word_count + 32'd1;
        end

        m_err_valid = 1'b0;
        if (rx_valid) begin
            if (m_ref_valid) begin
                pred         = lfsr_word(m_ref_state);
                diff_bits    = count_set_bits(rx_data ^ pred);
                m_bit_errors = bit_count_t'(diff_bits);
                m_err_valid  = m_locked && (diff_bits != 0);
                if (diff_bits != 0) begin
                    m_good = 0;
                    if (m_locked) begin
                        m_bad++;
                        if (m_bad == LOSS_BAD_WORDS) begin
                            m_locked = 1'b0;
                            m_bad    = 0;
                        end
                    end
                end else begin
                    m_bad = 0;
                    if (!m_locked) begin
                        m_good++;
                        if (m_good == LOCK_GOOD_WORDS) begin
                            m_locked = 1'b1;
                            m_good   = 0;
                        end
                    end
                end
            end
            m_ref_state = rx_data[PRBS_ORDER-1:0];   // As received, errors included
            m_ref_valid = 1'b1;
        end

        m_tx_valid = n_tx_en;
        if (n_tx_en) begin
            word        = lfsr_word(m_gen_state);
            m_tx_data   = word ^ prbs_word_t'(n_inject);
            m_gen_state = word[PRBS_ORDER-1:0];
        end
    endtask

    task automatic wait_tx_valid(input int limit);
        int n;
        n = 0;
        while (tx_valid !== 1'b1) begin
            if (n >= limit) begin
                timeout_fail("tx_valid never went high");
            end else begin
                run_cycle(70, 0, 0, 1'b0);
                n++;
            end
        end
    endtask

    task automatic wait_locked(input int limit);
        int n;
        n = 0;
        while (locked !== 1'b1) begin
            if (n >= limit) begin
                timeout_fail("checker did not lock on clean loopback");
            end else begin
                run_cycle(70, 0, 0, 1'b0);
                n++;
            end
        end
    endtask

    initial begin
        seed_val     = $urandom(50636);
        fail_count   = 0;
        loopback     = 1'b0;
        reset        = 1'b1;
        tx_enable    = 1'b0;
        inject_error = 1'b0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        clear_counts = 1'b0;

        m_gen_state  = PRBS_SEED;
        m_tx_valid   = 1'b0;
        m_tx_data    = '0;
        m_ref_state  = '0;
        m_ref_valid  = 1'b0;
        m_locked     = 1'b0;
        m_good       = 0;
        m_bad        = 0;
        m_bit_errors = '0;
        m_err_valid  = 1'b0;
        m_err_count  = '0;
        m_word_count = '0;

        repeat (5) @(posedge clk);

        // Transmitter alone, nothing sent until enabled
        repeat (4) run_cycle(0, 0, 0, 1'b0);
        wait_tx_valid(50);
        repeat (100) run_cycle(70, 0, 0, 1'b0);

        // Clean loopback
        loopback = 1'b1;
        wait_locked(100);
        repeat (50) run_cycle(70, 0, 0, 1'b0);
        check(64'(error_word_count), 64'd0, "no errors on clean loopback");

        // Single-bit injection while locked
        repeat (400) run_cycle(70, 4, 0, 1'b0);
        check(64'(error_word_count != 0), 64'd1, "injected errors were counted");

        // Random multi-bit corruption
        repeat (300) run_cycle(70, 0, 20, 1'b0);
        repeat (4) run_cycle(100, 0, 0, 1'b0);   // Flush spoiled reference and pending counts
        wait_locked(200);
        words_before = error_word_count;
        repeat (12) run_cycle(100, 0, 100, 1'b0);
        repeat (3) run_cycle(70, 0, 0, 1'b0);
        check(64'(locked), 64'd0, "lock lost after corrupted run");
        check(64'(error_word_count - words_before), 64'd4, "only locked errored words counted");

        // Relock after loss
        wait_locked(200);
        repeat (20) run_cycle(70, 0, 0, 1'b0);

        run_cycle(70, 0, 0, 1'b1);
        run_cycle(70, 0, 0, 1'b0);
        check(64'(error_count), 64'd0, "error_count after clear");
        check(64'(error_word_count), 64'd0, "error_word_count after clear");

        // Clear on the same edge as an err_valid strobe
        wait_cycles = 0;
        while (!m_err_valid) begin
            if (wait_cycles >= 300) begin
                timeout_fail("no errored word seen before clear test");
            end else begin
                run_cycle(70, 30, 0, 1'b0);
                wait_cycles++;
            end
        end
        run_cycle(70, 0, 0, 1'b1);
        run_cycle(70, 0, 0, 1'b0);
        check(64'(error_count), 64'd0, "clear beats err_valid, bit count");
        check(64'(error_word_count), 64'd0, "clear beats err_valid, word count");

        repeat (20) run_cycle(70, 0, 0, 1'b0);

        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/prbs_pkg.sv
design/prbs_7_64b.sv
design/prbs_gen.sv
design/prbs_check.sv
design/prbs_err_count.sv
design/prbs_top.sv
sim/tb_prbs_top.sv

// File: Makefile
# Verilator build and run of the PRBS7 testbench

VERILATOR ?= verilator
TOP       ?= tb_prbs_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

test: $(SIM_BIN)
	@rm -f $(LOG)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST RESULT: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
